//--- vlog.f
src/exu_pkg.sv
src/alu_exec.sv
src/exu_mem_seg_reg.sv
src/mem_stage.sv
src/pipe_ctrl.sv
src/exu_mem_top.sv
dv/tb_clkgen.sv
dv/tb_exu_mem.sv

//--- Makefile
# Verilator build and run of the execute / memory back end

TOP       ?= tb_exu_mem
SEED      ?= 111695761
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build from vlog.f, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP SEED LOG VERILATOR OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) -Gseed=$(SEED) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_exu_mem.sv
// ==================================================
// tb_exu_mem
// testbench for the execute / memory back end, with
// an in-order record queue, a shadow ram and
// concurrent checks on every writeback record
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module tb_exu_mem #(
        parameter int unsigned seed = 32'h06a8_5791
);

        logic            clk;
        logic            reset;
        logic            mem_wait;
        exu_pkg::issue_t issue;
        exu_pkg::wb_t    wb;
        logic            halted;

        // model state
        exu_pkg::wb_t    exp_q[$];
        int              lat_q[$];
        exu_pkg::wb_t    exp_rec;
        int              exp_lat      = 0;
        logic            chk_valid    = 1'b0;
        logic            orphan       = 1'b0;
        logic            squash_next  = 1'b0;
        logic [31:0]     shadow [64];

        // stimulus state
        logic            started      = 1'b0;
        logic            wait_on      = 1'b0;
        int              wait_left    = 0;
        logic [31:0]     next_pc      = 32'h0000_1000;

        int              cyc          = 0;
        int              checks       = 0;
        int              tests        = 0;
        int              errors       = 0;
        int              assert_errs  = 0;
        int              fails_before = 0;

        tb_clkgen i_clkgen (
                .clk   (clk),
                .reset (reset)
        );

        exu_mem_top i_dut (
                .clk      (clk),
                .reset    (reset),
                .mem_wait (mem_wait),
                .issue    (issue),
                .wb       (wb),
                .halted   (halted)
        );

        // ==================================================
        // reference rules
        // ==================================================
        function automatic logic [31:0] alu_ref(input exu_pkg::alu_op_e op,
                                                input logic [31:0] a, input logic [31:0] b);
                case (op)
                        exu_pkg::alu_add:    return a + b;
                        exu_pkg::alu_sub:    return a - b;
                        exu_pkg::alu_and:    return a & b;
                        exu_pkg::alu_or:     return a | b;
                        exu_pkg::alu_xor:    return a ^ b;
                        exu_pkg::alu_sll:    return a << b[4:0];
                        exu_pkg::alu_srl:    return a >> b[4:0];
                        exu_pkg::alu_sra:    return $signed(a) >>> b[4:0];
                        exu_pkg::alu_slt:    return {31'b0, $signed(a) < $signed(b)};
                        exu_pkg::alu_sltu:   return {31'b0, a < b};
                        exu_pkg::alu_pass_b: return b;
                        default:             return 32'h0;
                endcase
        endfunction

        task automatic predict(input exu_pkg::issue_t op);
                exu_pkg::wb_t rec;
                logic [31:0]  addr;
                int           w;
                int           b;
                addr            = op.src_a + op.imm;
                w               = int'(addr[7:2]);
                b               = int'(addr[1:0]);
                rec             = '0;
                rec.commit      = 1'b1;
                rec.pc          = op.pc;
                rec.rd          = op.rd;
                rec.write_gpr   = op.write_gpr & ~op.ebreak;
                rec.system_halt = op.ebreak;
                case (op.mem_op)
                        exu_pkg::mem_none: rec.data = alu_ref(op.alu_op, op.src_a, op.src_b);
                        exu_pkg::mem_lbu:  rec.data = {24'h0, shadow[w][8*b +: 8]};
                        exu_pkg::mem_sb: begin
                                shadow[w][8*b +: 8] = op.src_b[7:0];
                                rec.data = addr;
                        end
                        default: begin
                                if (b != 0) begin
                                        // word access off a word boundary traps
                                        rec.commit    = 1'b0;
                                        rec.write_gpr = 1'b0;
                                        rec.trap      = 1'b1;
                                        squash_next   = 1'b1;
                                end else if (op.mem_op == exu_pkg::mem_lw) begin
                                        rec.data = shadow[w];
                                end else begin
                                        shadow[w] = op.src_b;
                                        rec.data  = addr;
                                end
                        end
                endcase
                exp_q.push_back(rec);
                lat_q.push_back(cyc);
        endtask

        // issue slots are taken on rising edges without mem_wait
        always @(posedge clk) begin
                if (reset === 1'b0 && !mem_wait) begin
                        if (squash_next) begin
                                // flushed behind the trapping access
                                squash_next = 1'b0;
                        end else if (issue.commit) begin
                                predict(issue);
                        end
                end
        end

        always @(negedge clk) begin
                cyc       = cyc + 1;
                chk_valid = 1'b0;
                orphan    = 1'b0;
                if (reset === 1'b0 && (wb.commit || wb.trap)) begin
                        if (exp_q.size() == 0) begin
                                orphan = 1'b1;
                        end else begin
                                exp_rec   = exp_q.pop_front();
                                exp_lat   = cyc - lat_q.pop_front();
                                chk_valid = 1'b1;
                                checks    = checks + 1;
                        end
                end
        end

        // ==================================================
        // checks
        // ==================================================
        function automatic void report_mismatch(input string name, input logic [31:0] exp_v,
                                                input logic [31:0] act_v);
                $display("mismatch %s expected %h actual %h", name, exp_v, act_v);
                assert_errs = assert_errs + 1;
        endfunction

        function automatic void report_failure(input string msg);
                $display("%s", msg);
                assert_errs = assert_errs + 1;
        endfunction

        a_commit: assert property (@(posedge clk) disable iff (reset)
                        chk_valid |-> wb.commit == exp_rec.commit)
                else report_mismatch("wb.commit", 32'($sampled(exp_rec.commit)),
                                     32'($sampled(wb.commit)));
        a_trap: assert property (@(posedge clk) disable iff (reset)
                        chk_valid |-> wb.trap == exp_rec.trap)
                else report_mismatch("wb.trap", 32'($sampled(exp_rec.trap)),
                                     32'($sampled(wb.trap)));
        a_pc: assert property (@(posedge clk) disable iff (reset)
                        chk_valid |-> wb.pc == exp_rec.pc)
                else report_mismatch("wb.pc", $sampled(exp_rec.pc), $sampled(wb.pc));
        a_rd: assert property (@(posedge clk) disable iff (reset)
                        chk_valid |-> wb.rd == exp_rec.rd)
                else report_mismatch("wb.rd", 32'($sampled(exp_rec.rd)), 32'($sampled(wb.rd)));
        a_data: assert property (@(posedge clk) disable iff (reset)
                        chk_valid && !exp_rec.trap |-> wb.data == exp_rec.data)
                else report_mismatch("wb.data", $sampled(exp_rec.data), $sampled(wb.data));
        a_write_gpr: assert property (@(posedge clk) disable iff (reset)
                        chk_valid |-> wb.write_gpr == exp_rec.write_gpr)
                else report_mismatch("wb.write_gpr", 32'($sampled(exp_rec.write_gpr)),
                                     32'($sampled(wb.write_gpr)));
        a_system_halt: assert property (@(posedge clk) disable iff (reset)
                        chk_valid |-> wb.system_halt == exp_rec.system_halt)
                else report_mismatch("wb.system_halt", 32'($sampled(exp_rec.system_halt)),
                                     32'($sampled(wb.system_halt)));
        a_latency: assert property (@(posedge clk) disable iff (reset)
                        chk_valid && !wait_on |-> exp_lat == 2)
                else report_mismatch("wb latency", 32'd2, $sampled(exp_lat));
        a_orphan: assert property (@(posedge clk) disable iff (reset) !orphan)
                else report_failure("writeback record appeared with no op left to match");
        a_idle: assert property (@(posedge clk) disable iff (reset)
                        !started |-> !wb.commit && !wb.trap && !halted)
                else report_failure("record or halt seen before the first issue");
        a_wait_bubble: assert property (@(posedge clk) disable iff (reset)
                        mem_wait |=> !wb.commit && !wb.trap)
                else report_failure("a record left the memory stage during mem_wait");
        a_halt_set: assert property (@(posedge clk) disable iff (reset)
                        wb.commit && wb.system_halt |=> halted)
                else report_failure("halted did not rise after a halt record");
        a_halt_stays: assert property (@(posedge clk) disable iff (reset)
                        halted |=> halted)
                else report_failure("halted dropped before reset");

        // ==================================================
        // stimulus
        // ==================================================
        function automatic exu_pkg::issue_t make_op(input exu_pkg::alu_op_e aop,
                        input exu_pkg::mem_op_e mop, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] imm, input logic brk);
                exu_pkg::issue_t op;
                op           = '0;
                op.commit    = 1'b1;
                op.src_a     = a;
                op.src_b     = b;
                op.imm       = imm;
                op.alu_op    = aop;
                op.mem_op    = mop;
                op.rd        = 5'(1 + $urandom % 31);
                op.write_gpr = (mop != exu_pkg::mem_sw) && (mop != exu_pkg::mem_sb);
                op.ebreak    = brk;
                return op;
        endfunction

        function automatic exu_pkg::issue_t rand_alu_op();
                return make_op(exu_pkg::alu_op_e'(4'($urandom % 11)), exu_pkg::mem_none,
                               $urandom, $urandom, 32'h0, 1'b0);
        endfunction

        // random upper bits in src_a, ram offset in imm
        function automatic exu_pkg::issue_t mem_op_at(input exu_pkg::mem_op_e mop,
                                                       input logic [7:0] addr);
                return make_op(exu_pkg::alu_add, mop, $urandom & 32'hffff_ff00, $urandom,
                               {24'h0, addr}, 1'b0);
        endfunction

        function automatic exu_pkg::issue_t rand_mem_op();
                exu_pkg::mem_op_e mop;
                logic [7:0]       addr;
                mop  = exu_pkg::mem_op_e'(3'(1 + $urandom % 4));
                addr = 8'($urandom % 64) << 2;
                if (mop == exu_pkg::mem_sb || mop == exu_pkg::mem_lbu) begin
                        addr[1:0] = 2'($urandom % 4);
                end
                return mem_op_at(mop, addr);
        endfunction

        // random mem_wait bursts while enabled
        task automatic step_wait();
                if (!wait_on) begin
                        mem_wait = 1'b0;
                end else if (wait_left > 0) begin
                        mem_wait  = 1'b1;
                        wait_left = wait_left - 1;
                end else begin
                        mem_wait = 1'b0;
                        if ($urandom % 4 == 0) begin
                                wait_left = 1 + int'($urandom % 5);
                        end
                end
        endtask

        task automatic send(input exu_pkg::issue_t op);
                int   n;
                logic taken;
                op.pc   = next_pc;
                next_pc = next_pc + 4;
                issue   = op;
                started = 1'b1;
                taken   = 1'b0;
                for (n = 0; n < 40 && !taken; n++) begin
                        @(posedge clk);
                        taken = ~mem_wait;
                        @(negedge clk);
                        step_wait();
                end
                if (!taken) begin
                        $display("op at pc %h was never taken from the issue port", op.pc);
                        errors++;
                end
                issue.commit = 1'b0;
        endtask

        task automatic end_test(input int num, input string name);
                int n;
                int fails;
                for (n = 0; n < 300 && exp_q.size() != 0; n++) begin
                        @(negedge clk);
                end
                if (exp_q.size() != 0) begin
                        $display("timeout with %0d expected records still missing", exp_q.size());
                        errors++;
                end
                // give the last record time to reach its checks
                repeat (3) @(negedge clk);
                fails        = errors + assert_errs - fails_before;
                fails_before = errors + assert_errs;
                tests        = tests + 1;
                $display("test %0d %-8s %s", num, name, (fails == 0) ? "ok" : "failed");
        endtask

        initial begin
                int i;
                int n;
                issue    = '0;
                mem_wait = 1'b0;
                void'($urandom(seed));
                for (n = 0; n < 20 && reset !== 1'b0; n++) begin
                        @(negedge clk);
                end
                if (reset !== 1'b0) begin
                        $display("reset was never released");
                        errors++;
                end

                // nothing may come out before the first issue
                repeat (8) @(negedge clk);
                end_test(1, "idle");

                for (i = 0; i < 40; i++) begin
                        send(rand_alu_op());
                end
                end_test(2, "alu");

                // fill every word first so later loads never see x
                for (i = 0; i < 64; i++) begin
                        send(mem_op_at(exu_pkg::mem_sw, 8'(i * 4)));
                end
                for (i = 0; i < 60; i++) begin
                        send(rand_mem_op());
                end
                // byte merge into one word, read back whole and as a lane
                send(mem_op_at(exu_pkg::mem_sb, 8'h15));
                send(mem_op_at(exu_pkg::mem_lw, 8'h14));
                send(mem_op_at(exu_pkg::mem_lbu, 8'h15));
                end_test(3, "memory");

                wait_on = 1'b1;
                for (i = 0; i < 80; i++) begin
                        send(($urandom % 2 == 0) ? rand_alu_op() : rand_mem_op());
                end
                wait_left = 0;
                mem_wait  = 1'b0;
                end_test(4, "stall");
                wait_on = 1'b0;

                // the alu op right behind each bad access is flushed
                send(mem_op_at(exu_pkg::mem_lw, 8'h22));
                send(rand_alu_op());
                send(mem_op_at(exu_pkg::mem_sw, 8'h41));
                send(rand_alu_op());
                send(mem_op_at(exu_pkg::mem_lw, 8'h40));
                send(mem_op_at(exu_pkg::mem_lw, 8'h20));
                end_test(5, "misalign");

                send(make_op(exu_pkg::alu_add, exu_pkg::mem_none, $urandom, $urandom,
                             32'h0, 1'b1));
                for (n = 0; n < 20 && halted !== 1'b1; n++) begin
                        @(negedge clk);
                end
                if (halted !== 1'b1) begin
                        $display("halted did not rise after the ebreak");
                        errors++;
                end
                end_test(6, "halt");

                $display("tests %0d checks %0d errors %0d", tests, checks, errors + assert_errs);
                if (errors + assert_errs == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
// ==================================================
// tb_clkgen
// testbench clock, 40 ns period, and a reset held
// for the first four rising edges
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
        output logic clk,
        output logic reset
);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        initial begin
                reset = 1'b1;
                repeat (4) @(posedge clk);
                // release away from the active edge
                @(negedge clk);
                reset = 1'b0;
        end

endmodule

`default_nettype wire

//--- src/exu_mem_top.sv
// ==================================================
// exu_mem_top
// execute and memory back end of the rv32 pipeline
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module exu_mem_top (
        input  logic            clk,
        input  logic            reset,
        input  logic            mem_wait,
        input  exu_pkg::issue_t issue,
        output exu_pkg::wb_t    wb,
        output logic            halted
);

        exu_pkg::ex_mem_t ex_out;
        exu_pkg::ex_mem_t mem_in;
        logic             stall_me;
        logic             flush_ex;
        logic             misalign;

        alu_exec i_alu_exec (
                .issue  (issue),
                .ex_out (ex_out)
        );

        exu_mem_seg_reg i_seg_reg (
                .clk      (clk),
                .reset    (reset),
                .stall_me (stall_me),
                .flush_ex (flush_ex),
                .ex_in    (ex_out),
                .mem_in   (mem_in)
        );

        mem_stage i_mem_stage (
                .clk      (clk),
                .reset    (reset),
                .stall_me (stall_me),
                .mem_in   (mem_in),
                .misalign (misalign),
                .wb       (wb)
        );

        pipe_ctrl i_pipe_ctrl (
                .clk      (clk),
                .reset    (reset),
                .mem_wait (mem_wait),
                .misalign (misalign),
                .wb       (wb),
                .stall_me (stall_me),
                .flush_ex (flush_ex),
                .halted   (halted)
        );

endmodule

`default_nettype wire

//--- src/pipe_ctrl.sv
// ==================================================
// pipe_ctrl
// stall and flush for the memory segment, plus the
// sticky halted state
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
        input  logic         clk,
        input  logic         reset,
        input  logic         mem_wait,
        input  logic         misalign,
        input  exu_pkg::wb_t wb,
        output logic         stall_me,
        output logic         flush_ex,
        output logic         halted
);

        assign stall_me = mem_wait;

        // squash the younger op behind a trapping access
        assign flush_ex = misalign & ~mem_wait;

        // set by a retiring ebreak, cleared only by reset
        always_ff @(posedge clk) begin
                if (reset) begin
                        halted <= 1'b0;
                end else if (wb.commit && wb.system_halt) begin
                        halted <= 1'b1;
                end
        end

        a_no_flush_in_stall: assert property (
                @(posedge clk) disable iff (reset)
                !(flush_ex && stall_me)
        ) else $error("pipe_ctrl: flush and stall high together");

endmodule

`default_nettype wire

//--- src/mem_stage.sv
// ==================================================
// mem_stage
// data ram with byte lanes, misalignment check and
// the registered writeback record
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module mem_stage (
        input  logic             clk,
        input  logic             reset,
        input  logic             stall_me,
        input  exu_pkg::ex_mem_t mem_in,
        output logic             misalign,
        output exu_pkg::wb_t     wb
);

        logic [exu_pkg::xlen-1:0]    dmem [exu_pkg::dmem_words];
        logic [exu_pkg::dmem_aw-1:0] word_idx;
        logic [1:0]                  byte_sel;
        logic                        is_word_op;
        logic                        is_store;
        logic                        is_load;
        logic                        dmem_we;
        logic [exu_pkg::xlen-1:0]    rd_word;
        logic [7:0]                  rd_byte;
        logic [exu_pkg::xlen-1:0]    load_data;

        // ==================================================
        // address decode
        // ==================================================
        assign word_idx = mem_in.alu_out[exu_pkg::dmem_aw+1:2];
        assign byte_sel = mem_in.alu_out[1:0];

        assign is_word_op = (mem_in.mem_op == exu_pkg::mem_lw) ||
                            (mem_in.mem_op == exu_pkg::mem_sw);
        assign is_store   = (mem_in.mem_op == exu_pkg::mem_sw) ||
                            (mem_in.mem_op == exu_pkg::mem_sb);
        assign is_load    = (mem_in.mem_op == exu_pkg::mem_lw) ||
                            (mem_in.mem_op == exu_pkg::mem_lbu);

        // word accesses need a word aligned address
        assign misalign = mem_in.commit & is_word_op & (byte_sel != 2'b00);

        assign dmem_we = mem_in.commit & is_store & ~stall_me & ~misalign;

        // ==================================================
        // data ram
        // ==================================================
        always_ff @(posedge clk) begin
                if (dmem_we) begin
                        if (mem_in.mem_op == exu_pkg::mem_sb) begin
                                // merge a single lane, keep the rest
                                dmem[word_idx][8*byte_sel +: 8] <= mem_in.store_data[7:0];
                        end else begin
                                dmem[word_idx] <= mem_in.store_data;
                        end
                end
        end

        assign rd_word   = dmem[word_idx];
        assign rd_byte   = rd_word[8*byte_sel +: 8];
        assign load_data = (mem_in.mem_op == exu_pkg::mem_lbu) ?
                           {{(exu_pkg::xlen-8){1'b0}}, rd_byte} : rd_word;

        // ==================================================
        // writeback record
        // ==================================================
        always_ff @(posedge clk) begin
                if (reset || stall_me) begin
                        // bubble
                        wb    <= '0;
                        wb.pc <= exu_pkg::pc_rst;
                end else begin
                        // a trapping op leaves as trap, not as commit
                        wb.commit      <= mem_in.commit & ~misalign;
                        wb.pc          <= mem_in.pc;
                        wb.rd          <= mem_in.rd;
                        wb.data        <= is_load ? load_data : mem_in.alu_out;
                        wb.write_gpr   <= mem_in.commit & mem_in.write_gpr & ~misalign;
                        wb.system_halt <= mem_in.commit & mem_in.system_halt;
                        wb.trap        <= misalign;
                end
        end

        a_trap_record: assert property (
                @(posedge clk) disable iff (reset)
                (misalign && !stall_me) |=> (wb.trap && !wb.write_gpr)
        ) else $error("mem_stage: misaligned access did not give a clean trap record");

        // the addressed word keeps its contents across a stall cycle
        a_no_write_stalled: assert property (
                @(posedge clk) disable iff (reset)
                stall_me |=> (dmem[$past(word_idx)] === $past(rd_word))
        ) else $error("mem_stage: ram written during stall");

endmodule

`default_nettype wire

//--- src/exu_mem_seg_reg.sv
// ==================================================
// exu_mem_seg_reg
// execute to memory pipeline register, stall has
// priority over flush
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module exu_mem_seg_reg (
        input  logic             clk,
        input  logic             reset,
        input  logic             stall_me,
        input  logic             flush_ex,
        input  exu_pkg::ex_mem_t ex_in,
        output exu_pkg::ex_mem_t mem_in
);

        logic load_empty;

        // a flush under stall is ignored
        assign load_empty = reset | (flush_ex & ~stall_me);

        always_ff @(posedge clk) begin
                if (load_empty) begin
                        // empty slot, only the pc is nonzero
                        mem_in    <= '0;
                        mem_in.pc <= exu_pkg::pc_rst;
                end else if (~stall_me) begin
                        mem_in <= ex_in;
                end
        end

        // slot must stay frozen for the whole stall
        a_hold_on_stall: assert property (
                @(posedge clk) disable iff (reset)
                stall_me |=> $stable(mem_in)
        ) else $error("exu_mem_seg_reg: slot changed while stalled");

endmodule

`default_nettype wire

//--- src/alu_exec.sv
// ==================================================
// alu_exec
// execute stage: alu result, address generation
// and the halt flag raised by ebreak
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module alu_exec (
        input  exu_pkg::issue_t  issue,
        output exu_pkg::ex_mem_t ex_out
);

        logic [4:0]               shamt;
        logic                     is_mem;
        logic                     lt_s;
        logic                     lt_u;
        logic [exu_pkg::xlen-1:0] alu_res;
        logic [exu_pkg::xlen-1:0] mem_addr;

        // only the low five bits count for rv32 shifts
        assign shamt  = issue.src_b[4:0];
        assign is_mem = (issue.mem_op != exu_pkg::mem_none);
        assign lt_s   = ($signed(issue.src_a) < $signed(issue.src_b));
        assign lt_u   = (issue.src_a < issue.src_b);

        // effective address for loads and stores
        assign mem_addr = issue.src_a + issue.imm;

        always_comb begin
                case (issue.alu_op)
                        exu_pkg::alu_add:    alu_res = issue.src_a + issue.src_b;
                        exu_pkg::alu_sub:    alu_res = issue.src_a - issue.src_b;
                        exu_pkg::alu_and:    alu_res = issue.src_a & issue.src_b;
                        exu_pkg::alu_or:     alu_res = issue.src_a | issue.src_b;
                        exu_pkg::alu_xor:    alu_res = issue.src_a ^ issue.src_b;
                        exu_pkg::alu_sll:    alu_res = issue.src_a << shamt;
                        exu_pkg::alu_srl:    alu_res = issue.src_a >> shamt;
                        exu_pkg::alu_sra:    alu_res = $signed(issue.src_a) >>> shamt;
                        exu_pkg::alu_slt:    alu_res = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
                        exu_pkg::alu_sltu:   alu_res = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
                        exu_pkg::alu_pass_b: alu_res = issue.src_b;
                        default:             alu_res = '0;
                endcase
        end

        // ==================================================
        // execute record
        // ==================================================
        always_comb begin
                ex_out.commit     = issue.commit;
                ex_out.pc         = issue.pc;
                ex_out.alu_out    = is_mem ? mem_addr : alu_res;
                ex_out.store_data = is_mem ? issue.src_b : '0;
                ex_out.rd         = issue.rd;
                ex_out.mem_op     = issue.mem_op;
                // ebreak retires without a register write
                ex_out.write_gpr   = issue.write_gpr & ~issue.ebreak;
                ex_out.system_halt = issue.ebreak;
        end

endmodule

`default_nettype wire

//--- src/exu_pkg.sv
// ==================================================
// exu_pkg
// shared widths, opcodes and stage records for the
// execute / memory back end of the rv32 pipeline
// ==================================================

`default_nettype none

package exu_pkg;

        // ==================================================
        // sizes
        // ==================================================
        localparam int unsigned xlen       = 32;
        localparam int unsigned gpr_w      = 5;
        localparam int unsigned dmem_words = 64;
        localparam int unsigned dmem_aw    = $clog2(dmem_words);

        // pc of an empty pipeline slot
        localparam logic [xlen-1:0] pc_rst = 32'h8000_0000;

        // ==================================================
        // opcodes
        // ==================================================
        typedef enum logic [3:0] {
                alu_add    = 4'd0,
                alu_sub    = 4'd1,
                alu_and    = 4'd2,
                alu_or     = 4'd3,
                alu_xor    = 4'd4,
                alu_sll    = 4'd5,
                alu_srl    = 4'd6,
                alu_sra    = 4'd7,
                alu_slt    = 4'd8,
                alu_sltu   = 4'd9,
                alu_pass_b = 4'd10
        } alu_op_e;

        typedef enum logic [2:0] {
                mem_none = 3'd0,
                mem_lw   = 3'd1,
                mem_lbu  = 3'd2,
                mem_sw   = 3'd3,
                mem_sb   = 3'd4
        } mem_op_e;

        // ==================================================
        // stage records
        // ==================================================
        typedef struct packed {
                logic             commit;
                logic [xlen-1:0]  pc;
                logic [xlen-1:0]  src_a;
                logic [xlen-1:0]  src_b;
                logic [xlen-1:0]  imm;
                alu_op_e          alu_op;
                mem_op_e          mem_op;
                logic [gpr_w-1:0] rd;
                logic             write_gpr;
                logic             ebreak;
        } issue_t;

        typedef struct packed {
                logic             commit;
                logic [xlen-1:0]  pc;
                logic [xlen-1:0]  alu_out;
                logic [xlen-1:0]  store_data;
                logic [gpr_w-1:0] rd;
                logic             write_gpr;
                mem_op_e          mem_op;
                logic             system_halt;
        } ex_mem_t;

        typedef struct packed {
                logic             commit;
                logic [xlen-1:0]  pc;
                logic [gpr_w-1:0] rd;
                logic [xlen-1:0]  data;
                logic             write_gpr;
                logic             system_halt;
                logic             trap;
        } wb_t;

endpackage

`default_nettype wire
